// ==== src/noc_flit_pkg.sv ====
`default_nettype none

package noc_flit_pkg;

	// Every flit carries a type field on top of a fixed payload
	localparam int FLIT_TYPE_W = 2;
	localparam int PAYLOAD_W   = 32;

	// The type field sits in the two most significant bits of the flit
	localparam int FLIT_W = FLIT_TYPE_W + PAYLOAD_W;

	// One complete flit as it moves through buffers and links
	typedef logic [FLIT_W-1:0] flit_t;

	// Type field of a flit
	typedef logic [FLIT_TYPE_W-1:0] flit_type_t;

	// A HEAD flit opens a packet and claims the output until its TAIL passes
	localparam flit_type_t FLIT_HEAD = 2'd0;

	// BODY flits only appear between a HEAD and a TAIL
	localparam flit_type_t FLIT_BODY = 2'd1;

	// A TAIL flit closes the packet and frees the output for other inputs
	localparam flit_type_t FLIT_TAIL = 2'd2;

	// A one flit packet opens and closes in the same flit
	localparam flit_type_t FLIT_HEAD_TAIL = 2'd3;

endpackage

`default_nettype wire

// ==== src/round_robin_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module round_robin_arbiter #(
	parameter int NUM_PORTS = 4
) (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  update,
	input  wire [NUM_PORTS-1:0]  requests,
	output logic [NUM_PORTS-1:0] decision_oh
);

	// Pointer width still needs one bit when there is a single input
	localparam int PTR_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	// Input that has the highest priority in the current cycle
	logic [PTR_W-1:0] pointer;

	// Index of the granted input, only meaningful when any_grant is set
	logic [PTR_W-1:0] winner;
	logic             any_grant;

	// Cyclic search that starts at the pointer and stops at the first request
	always_comb begin
		int idx;
		decision_oh = '0;
		winner      = '0;
		any_grant   = 1'b0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			// Wrap the search index back to input 0 past the last input
			idx = int'(pointer) + i;
			if (idx >= NUM_PORTS) begin
				idx = idx - NUM_PORTS;
			end
			if (!any_grant && requests[idx]) begin
				decision_oh[idx] = 1'b1;
				winner           = PTR_W'(idx);
				any_grant        = 1'b1;
			end
		end
	end

	// The pointer only moves when the caller accepts the decision
	// The winner then drops to the lowest priority for the next round
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pointer <= '0;
		end else if (update && any_grant) begin
			if (winner == PTR_W'(NUM_PORTS - 1)) begin
				pointer <= '0;
			end else begin
				pointer <= winner + 1'b1;
			end
		end
	end

	// A grant goes to one requesting input at most and never to an idle one
	assert property (@(posedge clk) disable iff (reset)
		$onehot0(decision_oh) && ((decision_oh & ~requests) == '0))
	else
		$error("round robin decision is not a single requesting input");

endmodule

`default_nettype wire

// ==== src/grant_hold_round_robin_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module grant_hold_round_robin_arbiter #(
	parameter int NUM_PORTS = 4
) (
	input  wire                  clk,
	input  wire                  reset,
	input  wire [NUM_PORTS-1:0]  requests,
	input  wire [NUM_PORTS-1:0]  hold_in,
	output logic [NUM_PORTS-1:0] decision_oh
);

	// Fresh decision of the rotating priority arbiter
	logic [NUM_PORTS-1:0] grant_arb;

	// Decision issued in the previous cycle
	logic [NUM_PORTS-1:0] last;

	// Previous winner that still asks to keep the output
	logic [NUM_PORTS-1:0] hold;
	logic                 any_hold;

	// Priority rotates only when a new winner is picked
	logic                 update;

	round_robin_arbiter #(
		.NUM_PORTS(NUM_PORTS)
	) i_round_robin_arbiter (
		.clk        (clk),
		.reset      (reset),
		.update     (update),
		.requests   (requests),
		.decision_oh(grant_arb)
	);

	// Last is one-hot or zero so hold carries at most the previous winner
	assign hold     = last & hold_in;
	assign any_hold = |hold;

	// A held input keeps the grant even when its buffer has run dry
	assign decision_oh = any_hold ? hold : grant_arb;

	// Rotating during a hold would skip inputs once the hold ends
	assign update = !any_hold && |(grant_arb & requests);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			last <= '0;
		end else begin
			last <= decision_oh;
		end
	end

endmodule

`default_nettype wire

// ==== src/flit_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module flit_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 write,
	input  wire noc_flit_pkg::flit_t write_flit,
	input  wire                 pop,
	output noc_flit_pkg::flit_t head_flit,
	output logic                empty,
	output logic                full
);

	// Address width of the storage, one bit at least for a single entry
	localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	// Occupancy has to reach FIFO_DEPTH itself
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	noc_flit_pkg::flit_t mem [FIFO_DEPTH];

	logic [ADDR_W-1:0] rd_ptr;
	logic [ADDR_W-1:0] wr_ptr;
	logic [CNT_W-1:0]  count;

	// Pointers step through the storage and wrap at the last entry
	function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] ptr);
		if (ptr == ADDR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Storage is written at the edge and read combinationally at the head
	always_ff @(posedge clk) begin
		if (write) begin
			mem[wr_ptr] <= write_flit;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (write) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// A write and a pop together leave the occupancy unchanged
			case ({write, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The oldest flit is visible one cycle after it was written
	assign head_flit = mem[rd_ptr];

	// Both levels come straight from the registered occupancy
	assign empty = (count == '0);
	assign full  = (count == CNT_W'(FIFO_DEPTH));

	// Senders have to respect the full level of this buffer
	assert property (@(posedge clk) disable iff (reset) write |-> !full)
	else
		$error("flit written into a full input buffer");

	// The allocator must only pop inputs that hold a flit
	assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
	else
		$error("flit popped from an empty input buffer");

endmodule

`default_nettype wire

// ==== src/output_port_allocator.sv ====
`timescale 1ns/10ps
`default_nettype none

module output_port_allocator #(
	parameter int NUM_PORTS = 4
) (
	input  wire                              clk,
	input  wire                              reset,
	input  wire [NUM_PORTS-1:0]              empty,
	input  wire noc_flit_pkg::flit_type_t [NUM_PORTS-1:0] head_types,
	output logic [NUM_PORTS-1:0]             pop,
	output logic [NUM_PORTS-1:0]             grant
);

	// Every input with a flit at its head asks for the output
	logic [NUM_PORTS-1:0] requests;

	// Inputs whose packet has started but not yet ended
	logic [NUM_PORTS-1:0] open_pkt;

	assign requests = ~empty;

	// Open packets keep their grant so packets never interleave
	grant_hold_round_robin_arbiter #(
		.NUM_PORTS(NUM_PORTS)
	) i_grant_hold_round_robin_arbiter (
		.clk        (clk),
		.reset      (reset),
		.requests   (requests),
		.hold_in    (open_pkt),
		.decision_oh(grant)
	);

	// A held grant on an empty buffer gives no pop and the output idles
	assign pop = grant & ~empty;

	// Packet state follows the type of each flit that leaves its buffer
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			open_pkt <= '0;
		end else begin
			for (int i = 0; i < NUM_PORTS; i++) begin
				if (pop[i]) begin
					if (head_types[i] == noc_flit_pkg::FLIT_HEAD) begin
						open_pkt[i] <= 1'b1;
					end else if (head_types[i] == noc_flit_pkg::FLIT_TAIL) begin
						open_pkt[i] <= 1'b0;
					end
				end
			end
		end
	end

	// A packet in progress owns the output until its tail has gone
	assert property (@(posedge clk) disable iff (reset)
		(open_pkt != '0) |-> (grant == open_pkt))
	else
		$error("output granted away from an open packet");

	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_pkt_check
		// Body and tail flits only make sense inside a packet that has opened
		assert property (@(posedge clk) disable iff (reset)
			(pop[g] && (head_types[g] == noc_flit_pkg::FLIT_BODY ||
				head_types[g] == noc_flit_pkg::FLIT_TAIL)) |-> open_pkt[g])
		else
			$error("body or tail flit on input %0d without a head", g);
	end

endmodule

`default_nettype wire

// ==== src/switch_traversal.sv ====
`timescale 1ns/10ps
`default_nettype none

module switch_traversal #(
	parameter int NUM_PORTS = 4
) (
	input  wire                              clk,
	input  wire                              reset,
	input  wire [NUM_PORTS-1:0]              pop,
	input  wire noc_flit_pkg::flit_t [NUM_PORTS-1:0] head_flits,
	output logic                             out_valid,
	output noc_flit_pkg::flit_t              out_flit
);

	// Head flit of whichever input leaves in this cycle
	noc_flit_pkg::flit_t sel_flit;
	logic                any_pop;

	assign any_pop = |pop;

	// AND-OR mux that relies on pop being one-hot
	always_comb begin
		sel_flit = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (pop[i]) begin
				sel_flit = sel_flit | head_flits[i];
			end
		end
	end

	// Only out_valid tells the receiver whether the link carries a flit
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= any_pop;
		end
	end

	// The flit register holds its value while the link is idle
	always_ff @(posedge clk) begin
		if (any_pop) begin
			out_flit <= sel_flit;
		end
	end

	// Two inputs leaving together would merge their flits in the mux
	assert property (@(posedge clk) disable iff (reset) $onehot0(pop))
	else
		$error("more than one input popped onto the output link");

endmodule

`default_nettype wire

// ==== src/router_output_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module router_output_port #(
	parameter int NUM_PORTS  = 4,
	parameter int FIFO_DEPTH = 4
) (
	input  wire                              clk,
	input  wire                              reset,
	input  wire [NUM_PORTS-1:0]              in_valid,
	input  wire noc_flit_pkg::flit_t [NUM_PORTS-1:0] in_flit,
	output logic [NUM_PORTS-1:0]             in_full,
	output logic                             out_valid,
	output noc_flit_pkg::flit_t              out_flit
);

	// Oldest flit of every input buffer
	noc_flit_pkg::flit_t [NUM_PORTS-1:0]      head_flits;

	// Type fields of those flits for the packet tracking
	noc_flit_pkg::flit_type_t [NUM_PORTS-1:0] head_types;

	logic [NUM_PORTS-1:0] empty;
	logic [NUM_PORTS-1:0] pop;

	// One buffer per input link
	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_input
		flit_fifo #(
			.FIFO_DEPTH(FIFO_DEPTH)
		) i_flit_fifo (
			.clk       (clk),
			.reset     (reset),
			.write     (in_valid[g]),
			.write_flit(in_flit[g]),
			.pop       (pop[g]),
			.head_flit (head_flits[g]),
			.empty     (empty[g]),
			.full      (in_full[g])
		);

		// The type field is the top slice of each flit
		assign head_types[g] =
			head_flits[g][noc_flit_pkg::FLIT_W-1 -: noc_flit_pkg::FLIT_TYPE_W];
	end

	// Picks the input that owns the output and pops its head flit
	output_port_allocator #(
		.NUM_PORTS(NUM_PORTS)
	) i_output_port_allocator (
		.clk       (clk),
		.reset     (reset),
		.empty     (empty),
		.head_types(head_types),
		.pop       (pop),
		.grant     ()
	);

	// Moves the popped flit into the output register
	switch_traversal #(
		.NUM_PORTS(NUM_PORTS)
	) i_switch_traversal (
		.clk       (clk),
		.reset     (reset),
		.pop       (pop),
		.head_flits(head_flits),
		.out_valid (out_valid),
		.out_flit  (out_flit)
	);

endmodule

`default_nettype wire

// ==== tb/tb_router_output_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_router_output_port;

	localparam int NUM_PORTS    = 4;
	localparam int FIFO_DEPTH   = 4;
	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 4;

	// Rough length of each test in clock cycles
	localparam int LATENCY_CYCLES = NUM_PORTS * 12;
	localparam int RR_CYCLES      = 3 * 14;
	localparam int PACKET_CYCLES  = 20;
	localparam int GAP_CYCLES     = 24;
	localparam int FULL_CYCLES    = 28;
	localparam int TOTAL_CYCLES   = RESET_CYCLES + LATENCY_CYCLES + RR_CYCLES +
		PACKET_CYCLES + GAP_CYCLES + FULL_CYCLES;

	// The watchdog allows this many times the summed test lengths
	localparam int MARGIN = 4;

	// Longest wait for the expected flits of one step
	localparam int WAIT_LIMIT = 40;

	logic                                clk;
	logic                                reset;
	logic [NUM_PORTS-1:0]                in_valid;
	noc_flit_pkg::flit_t [NUM_PORTS-1:0] in_flit;
	logic [NUM_PORTS-1:0]                in_full;
	logic                                out_valid;
	noc_flit_pkg::flit_t                 out_flit;

	integer seed;
	int     errors;
	int     cycle = 0;

	// Flits seen on the output link with the cycle they were seen in
	noc_flit_pkg::flit_t out_q[$];
	int                  out_cyc[$];

	// Flits the current test expects, in order
	noc_flit_pkg::flit_t exp_q[$];

	router_output_port #(
		.NUM_PORTS (NUM_PORTS),
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_router_output_port (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.in_flit  (in_flit),
		.in_full  (in_full),
		.out_valid(out_valid),
		.out_flit (out_flit)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Counts rising edges, so it is stable whenever the falling edge reads it
	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// Outputs change at the rising edge and are collected at the falling one
	always @(negedge clk) begin
		if (!reset && out_valid) begin
			out_q.push_back(out_flit);
			out_cyc.push_back(cycle);
		end
	end

	initial begin
		#(TOTAL_CYCLES * MARGIN * CLK_PERIOD);
		$display("Watchdog expired at cycle %0d with the tests still running", cycle);
		$display("TEST FAILED");
		$finish;
	end

	// Type field on top, a fresh random payload below it
	function automatic noc_flit_pkg::flit_t make_flit(input noc_flit_pkg::flit_type_t ftype);
		logic [noc_flit_pkg::PAYLOAD_W-1:0] payload;
		payload = $random(seed);
		return {ftype, payload};
	endfunction

	// A packet opens with a HEAD, closes with a TAIL and has BODY flits between
	function automatic noc_flit_pkg::flit_type_t packet_type(input int idx, input int len);
		if (idx == 0) begin
			return noc_flit_pkg::FLIT_HEAD;
		end
		if (idx == len - 1) begin
			return noc_flit_pkg::FLIT_TAIL;
		end
		return noc_flit_pkg::FLIT_BODY;
	endfunction

	task automatic check_value(input string test_name, input string what,
		input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s %s expected %h actual %h",
				test_name, what, expected, actual);
			errors++;
		end
	endtask

	// Moves to the next falling edge where all write strobes drop again
	task automatic advance();
		@(negedge clk);
		in_valid = '0;
	endtask

	// Presents one flit on one input until the next advance
	task automatic stage_flit(input int port, input noc_flit_pkg::flit_type_t ftype,
		output noc_flit_pkg::flit_t flit);
		flit = make_flit(ftype);
		in_valid[port] = 1'b1;
		in_flit[port]  = flit;
	endtask

	task automatic start_test();
		out_q.delete();
		out_cyc.delete();
		exp_q.delete();
	endtask

	task automatic wait_outputs(input string test_name, input int count);
		int waited;
		waited = 0;
		while (out_q.size() < count && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (out_q.size() < count) begin
			$display("%s: only %0d of %0d flits left the output port in time",
				test_name, out_q.size(), count);
			errors++;
		end
		// A few idle cycles show flits that should never have left
		repeat (4) @(negedge clk);
	endtask

	task automatic compare_outputs(input string test_name);
		check_value(test_name, "flit count", exp_q.size(), out_q.size());
		for (int i = 0; i < exp_q.size() && i < out_q.size(); i++) begin
			check_value(test_name, $sformatf("flit %0d", i), exp_q[i], out_q[i]);
		end
	endtask

	// A lone one-flit packet is written at the next edge and leaves one edge later
	task automatic test_latency();
		noc_flit_pkg::flit_t f;
		int                  drive_cyc;
		for (int p = 0; p < NUM_PORTS; p++) begin
			start_test();
			advance();
			stage_flit(p, noc_flit_pkg::FLIT_HEAD_TAIL, f);
			drive_cyc = cycle;
			exp_q.push_back(f);
			advance();
			wait_outputs("single_flit_latency", 1);
			compare_outputs("single_flit_latency");
			if (out_cyc.size() > 0) begin
				check_value("single_flit_latency", "latency", 2, out_cyc[0] - drive_cyc);
			end
		end
	endtask

	task automatic test_round_robin();
		noc_flit_pkg::flit_t f [NUM_PORTS];
		noc_flit_pkg::flit_t lone;
		// Input 3 won last in the latency test, so priority is back at input 0
		start_test();
		advance();
		for (int p = 0; p < NUM_PORTS; p++) begin
			stage_flit(p, noc_flit_pkg::FLIT_HEAD_TAIL, f[p]);
			exp_q.push_back(f[p]);
		end
		advance();
		wait_outputs("round_robin", NUM_PORTS);
		compare_outputs("round_robin");

		// A lone winner on input 1 hands the highest priority to input 2
		start_test();
		advance();
		stage_flit(1, noc_flit_pkg::FLIT_HEAD_TAIL, lone);
		exp_q.push_back(lone);
		advance();
		wait_outputs("round_robin", 1);
		compare_outputs("round_robin");

		start_test();
		advance();
		for (int p = 0; p < NUM_PORTS; p++) begin
			stage_flit(p, noc_flit_pkg::FLIT_HEAD_TAIL, f[p]);
		end
		for (int i = 0; i < NUM_PORTS; i++) begin
			exp_q.push_back(f[(i + 2) % NUM_PORTS]);
		end
		advance();
		wait_outputs("round_robin", NUM_PORTS);
		compare_outputs("round_robin");
	endtask

	task automatic test_no_interleave();
		noc_flit_pkg::flit_t pkt1 [3];
		noc_flit_pkg::flit_t pkt2 [3];
		start_test();
		for (int i = 0; i < 3; i++) begin
			advance();
			stage_flit(1, packet_type(i, 3), pkt1[i]);
			stage_flit(2, packet_type(i, 3), pkt2[i]);
		end
		advance();
		// Input 1 won last, so input 2 takes the output first and keeps it
		for (int i = 0; i < 3; i++) begin
			exp_q.push_back(pkt2[i]);
		end
		for (int i = 0; i < 3; i++) begin
			exp_q.push_back(pkt1[i]);
		end
		wait_outputs("no_interleave", 6);
		compare_outputs("no_interleave");
	endtask

	task automatic test_hold_gap();
		noc_flit_pkg::flit_t head;
		noc_flit_pkg::flit_t body0;
		noc_flit_pkg::flit_t body1;
		noc_flit_pkg::flit_t tail;
		noc_flit_pkg::flit_t waiting;
		start_test();
		advance();
		stage_flit(0, noc_flit_pkg::FLIT_HEAD, head);
		advance();
		stage_flit(0, noc_flit_pkg::FLIT_BODY, body0);
		// The head has left by now, so input 0 already owns the output
		advance();
		stage_flit(3, noc_flit_pkg::FLIT_HEAD_TAIL, waiting);
		repeat (4) advance();
		stage_flit(0, noc_flit_pkg::FLIT_BODY, body1);
		advance();
		stage_flit(0, noc_flit_pkg::FLIT_TAIL, tail);
		advance();
		exp_q.push_back(head);
		exp_q.push_back(body0);
		exp_q.push_back(body1);
		exp_q.push_back(tail);
		exp_q.push_back(waiting);
		wait_outputs("hold_gap", 5);
		compare_outputs("hold_gap");
		// Both body flits were presented five cycles apart and the link idles between
		if (out_cyc.size() >= 3) begin
			check_value("hold_gap", "idle gap", 5, out_cyc[2] - out_cyc[1]);
		end
	endtask

	task automatic test_full_level();
		noc_flit_pkg::flit_t head;
		noc_flit_pkg::flit_t tail;
		noc_flit_pkg::flit_t burst [FIFO_DEPTH];
		start_test();
		advance();
		stage_flit(0, noc_flit_pkg::FLIT_HEAD, head);
		advance();
		advance();
		// Input 0 holds the output with an empty buffer, so input 3 only fills
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			check_value("full_level", "in_full before write", 0, in_full[3]);
			stage_flit(3, noc_flit_pkg::FLIT_HEAD_TAIL, burst[i]);
			advance();
		end
		check_value("full_level", "in_full after burst", 1, in_full[3]);
		stage_flit(0, noc_flit_pkg::FLIT_TAIL, tail);
		advance();
		exp_q.push_back(head);
		exp_q.push_back(tail);
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			exp_q.push_back(burst[i]);
		end
		wait_outputs("full_level", 2 + FIFO_DEPTH);
		compare_outputs("full_level");
		check_value("full_level", "in_full after drain", 0, in_full);
	endtask

	initial begin
		seed     = 32'h1ea;
		errors   = 0;
		reset    = 1'b1;
		in_valid = '0;
		in_flit  = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		check_value("reset", "out_valid", 0, out_valid);
		check_value("reset", "in_full", 0, in_full);

		test_latency();
		test_round_robin();
		test_no_interleave();
		test_hold_gap();
		test_full_level();

		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/noc_flit_pkg.sv
src/round_robin_arbiter.sv
src/grant_hold_round_robin_arbiter.sv
src/flit_fifo.sv
src/output_port_allocator.sv
src/switch_traversal.sv
src/router_output_port.sv
tb/tb_router_output_port.sv

// ==== Bender.yml ====
package:
  name: router_output_port

sources:
  # Design sources, package first
  - files:
      - src/noc_flit_pkg.sv
      - src/round_robin_arbiter.sv
      - src/grant_hold_round_robin_arbiter.sv
      - src/flit_fifo.sv
      - src/output_port_allocator.sv
      - src/switch_traversal.sv
      - src/router_output_port.sv

  # Simulation only
  - target: test
    files:
      - tb/tb_router_output_port.sv
